// File: design/mcu_cfg_pkg.sv
/* Address map and register offsets of the peripherals,
   flash read opcode, default SPI and UART timing */
package mcu_cfg_pkg;

  // Slave select codes in address bits 13:12
  localparam logic [1:0] SLV_SOC   = 2'd0;
  localparam logic [1:0] SLV_UART  = 2'd1;
  localparam logic [1:0] SLV_FLASH = 2'd2;

  // soc_ctrl registers
  localparam logic [11:0] SOC_EXIT_OFS   = 12'h000;
  localparam logic [11:0] SOC_STATUS_OFS = 12'h004;

  // uart_tx registers
  localparam logic [11:0] UART_TXDATA_OFS = 12'h000;

  // spi_flash_ctrl registers
  localparam logic [11:0] FLASH_CMD_OFS    = 12'h000;
  localparam logic [11:0] FLASH_DATA_OFS   = 12'h004;
  localparam logic [11:0] FLASH_STATUS_OFS = 12'h008;

  // Standard serial flash read
  localparam logic [7:0] FLASH_READ_OPCODE = 8'h03;

  // Timing in core cycles
  localparam int DEF_SCK_DIV      = 2;
  localparam int DEF_CLKS_PER_BIT = 16;

endpackage

// File: design/mcu_bus_pkg.sv
/* APB request and response structs, flash pad bundle
   and the two views of the flash command word */
package mcu_bus_pkg;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // Controller side of the flash pads
  typedef struct packed {
    logic       csb;
    logic       sck;
    logic [3:0] oe;
    logic [3:0] dout;
  } spi_pad_t;

  typedef struct packed {
    logic [7:0]  opcode;
    logic [23:0] addr;
  } flash_cmd_t;

  // Opcode check on one view, shift register load from the other
  typedef union packed {
    flash_cmd_t  cmd;
    logic [31:0] raw;
  } flash_cmd_u;

endpackage

// File: design/apb_periph_demux.sv
/* APB address decoder for soc_ctrl, uart_tx and the flash controller,
   with error response for unmapped addresses */
`timescale 1ns/1ns

module apb_periph_demux (
  input  mcu_bus_pkg::apb_req_t req_i,
  output mcu_bus_pkg::apb_rsp_t rsp_o,
  output mcu_bus_pkg::apb_req_t soc_req_o,
  output mcu_bus_pkg::apb_req_t uart_req_o,
  output mcu_bus_pkg::apb_req_t flash_req_o,
  input  mcu_bus_pkg::apb_rsp_t soc_rsp_i,
  input  mcu_bus_pkg::apb_rsp_t uart_rsp_i,
  input  mcu_bus_pkg::apb_rsp_t flash_rsp_i
);

  logic [1:0]            slv;
  logic                  hole;
  mcu_bus_pkg::apb_req_t base;

  assign slv  = req_i.paddr[13:12];
  // Anything above bit 13 is outside the map
  assign hole = |req_i.paddr[31:14];

  // Slaves only see their 12-bit offset
  always_comb begin
    base       = req_i;
    base.paddr = {20'd0, req_i.paddr[11:0]};
  end

  always_comb begin
    soc_req_o        = base;
    uart_req_o       = base;
    flash_req_o      = base;
    soc_req_o.psel   = req_i.psel & ~hole & (slv == mcu_cfg_pkg::SLV_SOC);
    uart_req_o.psel  = req_i.psel & ~hole & (slv == mcu_cfg_pkg::SLV_UART);
    flash_req_o.psel = req_i.psel & ~hole & (slv == mcu_cfg_pkg::SLV_FLASH);
  end

  // Response mux, holes answer at once with an error
  always_comb begin
    rsp_o.prdata  = '0;
    rsp_o.pready  = 1'b1;
    rsp_o.pslverr = 1'b1;
    if (!hole) begin
      case (slv)
        mcu_cfg_pkg::SLV_SOC:   rsp_o = soc_rsp_i;
        mcu_cfg_pkg::SLV_UART:  rsp_o = uart_rsp_i;
        mcu_cfg_pkg::SLV_FLASH: rsp_o = flash_rsp_i;
        default: ;
      endcase
    end
  end

endmodule

// File: design/soc_ctrl.sv
/* Exit value register with sticky valid flag,
   read-only status register with fetch enable */
`timescale 1ns/1ns

module soc_ctrl (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  mcu_bus_pkg::apb_req_t req_i,
  output mcu_bus_pkg::apb_rsp_t rsp_o,
  input  logic                  fetch_enable_i,
  output logic [31:0]           exit_value_o,
  output logic                  exit_valid_o
);

  logic [31:0] exit_q;
  logic        valid_q;
  logic        exit_wr;

  assign exit_wr = req_i.psel & req_i.penable & req_i.pwrite &
                   (req_i.paddr[11:0] == mcu_cfg_pkg::SOC_EXIT_OFS);

  // Valid stays set until reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (exit_wr) begin
      valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (exit_wr) begin
      exit_q <= req_i.pwdata;
    end
  end

  always_comb begin
    rsp_o.prdata  = '0;
    rsp_o.pready  = 1'b1;
    rsp_o.pslverr = 1'b0;
    case (req_i.paddr[11:0])
      mcu_cfg_pkg::SOC_EXIT_OFS:   rsp_o.prdata = exit_q;
      mcu_cfg_pkg::SOC_STATUS_OFS: begin
        rsp_o.prdata  = {31'd0, fetch_enable_i};
        rsp_o.pslverr = req_i.pwrite;
      end
      default: rsp_o.pslverr = 1'b1;
    endcase
  end

  assign exit_value_o = exit_q;
  assign exit_valid_o = valid_q;

endmodule

// File: design/uart_tx.sv
/* 8N1 UART transmitter written over APB, holds
   the bus in wait states while a frame is on the line */
`timescale 1ns/1ns

module uart_tx #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  mcu_bus_pkg::apb_req_t req_i,
  output mcu_bus_pkg::apb_rsp_t rsp_o,
  output logic                  tx_o
);

  localparam int CW = $clog2(CLKS_PER_BIT + 1);

  logic          busy_q;
  logic [CW-1:0] clk_q;
  logic [3:0]    bit_q;
  logic [9:0]    sh_q;
  logic          ofs_ok;
  logic          load;
  logic          bit_end;

  assign ofs_ok  = req_i.paddr[11:0] == mcu_cfg_pkg::UART_TXDATA_OFS;
  assign load    = req_i.psel & req_i.penable & req_i.pwrite & ofs_ok & ~busy_q;
  assign bit_end = busy_q & (clk_q == CW'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      clk_q  <= '0;
      bit_q  <= '0;
      sh_q   <= '1;
    end else if (load) begin
      // Stop, data LSB first, start
      busy_q <= 1'b1;
      clk_q  <= '0;
      bit_q  <= '0;
      sh_q   <= {1'b1, req_i.pwdata[7:0], 1'b0};
    end else if (busy_q) begin
      clk_q <= bit_end ? '0 : clk_q + CW'(1);
      if (bit_end) begin
        // Ones fill in, line is idle after the stop bit
        sh_q  <= {1'b1, sh_q[9:1]};
        bit_q <= bit_q + 4'd1;
        if (bit_q == 4'd9) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  assign tx_o = sh_q[0];

  always_comb begin
    rsp_o.prdata  = '0;
    rsp_o.pready  = ~(busy_q & req_i.pwrite & ofs_ok);
    rsp_o.pslverr = ~ofs_ok;
  end

endmodule

// File: design/spi_flash_ctrl.sv
/* SPI flash read engine programmed over APB, mode 0,
   32 command and address bits out on io0, 32 data bits in on io1 */
`timescale 1ns/1ns

module spi_flash_ctrl #(
  parameter int SCK_DIV = 2
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  mcu_bus_pkg::apb_req_t req_i,
  output mcu_bus_pkg::apb_rsp_t rsp_o,
  output mcu_bus_pkg::spi_pad_t pad_o,
  input  logic [3:0]            di_i
);

  localparam int DW = $clog2(SCK_DIV + 1);

  mcu_bus_pkg::flash_cmd_u wcmd;

  logic          cmd_wr;
  logic          cmd_err;
  logic          start;
  logic          busy_q;
  logic          done_q;
  logic          csb_q;
  logic          phase_q;
  logic          samp_q;
  logic [DW-1:0] div_q;
  logic [5:0]    bit_q;
  logic [31:0]   tx_q;
  logic [31:0]   rx_q;
  logic [31:0]   rx_next;
  logic [31:0]   data_q;
  logic          tick;
  logic          rise;
  logic          fall;
  logic          last;

  assign wcmd.raw = req_i.pwdata;
  assign cmd_wr   = req_i.psel & req_i.penable & req_i.pwrite &
                    (req_i.paddr[11:0] == mcu_cfg_pkg::FLASH_CMD_OFS);
  assign cmd_err  = busy_q | (wcmd.cmd.opcode != mcu_cfg_pkg::FLASH_READ_OPCODE);
  assign start    = cmd_wr & ~cmd_err;

  // SCK edge strobes
  assign tick = busy_q & (div_q == DW'(SCK_DIV - 1));
  assign rise = tick & ~phase_q;
  assign fall = tick & phase_q;
  assign last = fall & (bit_q == 6'd63);

  // io1 arrives through the pad capture register, so sample a cycle late
  assign rx_next = samp_q ? {rx_q[30:0], di_i[1]} : rx_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
      csb_q   <= 1'b1;
      phase_q <= 1'b0;
      samp_q  <= 1'b0;
      div_q   <= '0;
      bit_q   <= '0;
    end else begin
      samp_q <= rise;
      if (start) begin
        busy_q  <= 1'b1;
        done_q  <= 1'b0;
        csb_q   <= 1'b0;
        phase_q <= 1'b0;
        div_q   <= '0;
        bit_q   <= '0;
      end else if (busy_q) begin
        div_q <= tick ? '0 : div_q + DW'(1);
        if (tick) begin
          phase_q <= ~phase_q;
        end
        // One bit per falling edge
        if (fall) begin
          bit_q <= bit_q + 6'd1;
        end
        if (last) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
          csb_q  <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    rx_q <= rx_next;
    if (start) begin
      tx_q <= wcmd.raw;
    end else if (fall) begin
      tx_q <= {tx_q[30:0], 1'b0};
    end
    if (last) begin
      data_q <= rx_next;
    end
  end

  // io0 driven only during the command bits
  always_comb begin
    pad_o.csb  = csb_q;
    pad_o.sck  = phase_q;
    pad_o.oe   = {3'b000, busy_q & ~bit_q[5]};
    pad_o.dout = {3'b000, tx_q[31]};
  end

  always_comb begin
    rsp_o.prdata  = '0;
    rsp_o.pready  = 1'b1;
    rsp_o.pslverr = 1'b0;
    case (req_i.paddr[11:0])
      mcu_cfg_pkg::FLASH_CMD_OFS: rsp_o.pslverr = req_i.pwrite & cmd_err;
      mcu_cfg_pkg::FLASH_DATA_OFS: begin
        rsp_o.prdata  = data_q;
        rsp_o.pslverr = req_i.pwrite;
      end
      mcu_cfg_pkg::FLASH_STATUS_OFS: begin
        rsp_o.prdata  = {30'd0, done_q, busy_q};
        rsp_o.pslverr = req_i.pwrite;
      end
      default: rsp_o.pslverr = 1'b1;
    endcase
  end

endmodule

// File: design/flash_pad_ring.sv
/* Tristate drivers for the flash data lines
   and registered capture of the line values */
`timescale 1ns/1ns

module flash_pad_ring (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  mcu_bus_pkg::spi_pad_t pad_i,
  output logic [3:0]            di_o,
  inout  wire  [3:0]            dio,
  output logic                  csb_o,
  output logic                  sck_o
);

  // Line released when its enable is low
  for (genvar i = 0; i < 4; i++) begin : g_pad
    assign dio[i] = pad_i.oe[i] ? pad_i.dout[i] : 1'bz;
  end

  // Input capture stage
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      di_o <= '0;
    end else begin
      di_o <= dio;
    end
  end

  assign csb_o = pad_i.csb;
  assign sck_o = pad_i.sck;

endmodule

// File: design/mini_mcu_wrapper.sv
/* Board level shell with APB decoder, control block,
   UART transmitter, flash read controller and flash pads */
`timescale 1ns/1ns

module mini_mcu_wrapper #(
  parameter int SCK_DIV      = mcu_cfg_pkg::DEF_SCK_DIV,
  parameter int CLKS_PER_BIT = mcu_cfg_pkg::DEF_CLKS_PER_BIT
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  mcu_bus_pkg::apb_req_t apb_req_i,
  output mcu_bus_pkg::apb_rsp_t apb_rsp_o,
  input  logic                  fetch_enable_i,
  output logic                  uart_tx_o,
  output logic                  exit_value_o,
  output logic                  exit_valid_o,
  inout  wire  [3:0]            spi_flash_dio,
  output wire                   spi_flash_cs,
  output wire                   spi_flash_clk
);

  mcu_bus_pkg::apb_req_t soc_req;
  mcu_bus_pkg::apb_req_t uart_req;
  mcu_bus_pkg::apb_req_t flash_req;
  mcu_bus_pkg::apb_rsp_t soc_rsp;
  mcu_bus_pkg::apb_rsp_t uart_rsp;
  mcu_bus_pkg::apb_rsp_t flash_rsp;
  mcu_bus_pkg::spi_pad_t flash_pad;
  logic [3:0]            flash_di;
  logic [31:0]           exit_value;

  apb_periph_demux apb_periph_demux_i (
    .req_i      (apb_req_i),
    .rsp_o      (apb_rsp_o),
    .soc_req_o  (soc_req),
    .uart_req_o (uart_req),
    .flash_req_o(flash_req),
    .soc_rsp_i  (soc_rsp),
    .uart_rsp_i (uart_rsp),
    .flash_rsp_i(flash_rsp)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .req_i         (soc_req),
    .rsp_o         (soc_rsp),
    .fetch_enable_i(fetch_enable_i),
    .exit_value_o  (exit_value),
    .exit_valid_o  (exit_valid_o)
  );

  uart_tx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) uart_tx_i (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .req_i  (uart_req),
    .rsp_o  (uart_rsp),
    .tx_o   (uart_tx_o)
  );

  spi_flash_ctrl #(
    .SCK_DIV(SCK_DIV)
  ) spi_flash_ctrl_i (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .req_i  (flash_req),
    .rsp_o  (flash_rsp),
    .pad_o  (flash_pad),
    .di_i   (flash_di)
  );

  flash_pad_ring flash_pad_ring_i (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .pad_i  (flash_pad),
    .di_o   (flash_di),
    .dio    (spi_flash_dio),
    .csb_o  (spi_flash_cs),
    .sck_o  (spi_flash_clk)
  );

  // Only bit 0 of the exit code reaches the board
  assign exit_value_o = exit_value[0];

endmodule

// File: test/spi_flash_model.sv
/* Behavioral SPI flash that answers the 0x03 read command
   from a memory filled by an address rule */
`timescale 1ns/1ns

module spi_flash_model (
  input  logic       csb_i,
  input  logic       sck_i,
  inout  wire  [3:0] dio
);

  logic [6:0]  cnt_q;
  logic [31:0] cmd_q;
  logic [31:0] out_q;
  logic        drive_q;

  // Every address byte takes part in the fill value
  function automatic logic [7:0] mem_byte(input logic [23:0] a);
    return a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'h5A;
  endfunction

  // First byte goes out as the most significant
  function automatic logic [31:0] read_word(input logic [23:0] a);
    return {mem_byte(a), mem_byte(a + 24'd1), mem_byte(a + 24'd2), mem_byte(a + 24'd3)};
  endfunction

  // Opcode and address arrive on io0, sampled on rising SCK
  always @(posedge sck_i or posedge csb_i) begin
    if (csb_i) begin
      cnt_q <= '0;
    end else if (cnt_q < 7'd64) begin
      cnt_q <= cnt_q + 7'd1;
      if (cnt_q < 7'd32) begin
        cmd_q <= {cmd_q[30:0], dio[0]};
      end
    end
  end

  // Read data leaves on io1, shifted on falling SCK
  always @(negedge sck_i or posedge csb_i) begin
    if (csb_i) begin
      drive_q <= 1'b0;
    end else if (cnt_q == 7'd32) begin
      drive_q <= (cmd_q[31:24] == 8'h03);
      out_q   <= read_word(cmd_q[23:0]);
    end else if (cnt_q > 7'd32) begin
      out_q <= {out_q[30:0], 1'b0};
    end
  end

  assign dio[1] = drive_q ? out_q[31] : 1'bz;

endmodule

// File: test/tb_mini_mcu.sv
/* Testbench for the MCU wrapper with APB driver tasks,
   stimulus table, UART frame decoder and flash read checks */
`timescale 1ns/1ns

module tb_mini_mcu;

  localparam int     SCK_DIV      = 2;
  localparam int     CLKS_PER_BIT = 16;
  localparam int     CLK_PERIOD   = 8;
  localparam int     TIMEOUT      = 2000;
  localparam longint FRAME_NS     = 10 * CLKS_PER_BIT * CLK_PERIOD;

  // Slave code sits in address bits 13:12
  localparam logic [31:0] EXIT_ADDR   = 32'h0000_0000;
  localparam logic [31:0] STATUS_ADDR = 32'h0000_0004;
  localparam logic [31:0] TXDATA_ADDR = 32'h0000_1000;
  localparam logic [31:0] CMD_ADDR    = 32'h0000_2000;
  localparam logic [31:0] DATA_ADDR   = 32'h0000_2004;
  localparam logic [31:0] FSTAT_ADDR  = 32'h0000_2008;

  localparam logic [2:0] OP_WR    = 3'd0;
  localparam logic [2:0] OP_RD    = 3'd1;
  localparam logic [2:0] OP_FETCH = 3'd2;
  localparam logic [2:0] OP_EXIT  = 3'd3;
  localparam logic [2:0] OP_FLASH = 3'd4;
  localparam logic [2:0] OP_FBUSY = 3'd5;
  localparam logic [2:0] OP_UART  = 3'd6;

  typedef struct packed {
    logic [2:0]  op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        err;
  } entry_t;

  logic                  clk_i;
  logic                  reset_i;
  mcu_bus_pkg::apb_req_t apb_req;
  mcu_bus_pkg::apb_rsp_t apb_rsp;
  logic                  fetch_enable_i;
  logic                  uart_tx_o;
  logic                  exit_value_o;
  logic                  exit_valid_o;
  wire  [3:0]            flash_dio;
  wire                   flash_cs;
  wire                   flash_clk;
  entry_t                table_q[$];

  mini_mcu_wrapper #(
    .SCK_DIV     (SCK_DIV),
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) mini_mcu_wrapper_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .apb_req_i     (apb_req),
    .apb_rsp_o     (apb_rsp),
    .fetch_enable_i(fetch_enable_i),
    .uart_tx_o     (uart_tx_o),
    .exit_value_o  (exit_value_o),
    .exit_valid_o  (exit_valid_o),
    .spi_flash_dio (flash_dio),
    .spi_flash_cs  (flash_cs),
    .spi_flash_clk (flash_clk)
  );

  spi_flash_model spi_flash_model_i (
    .csb_i(flash_cs),
    .sck_i(flash_clk),
    .dio  (flash_dio)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic stop_run();
    $display("Errors found");
    $fatal(1, "Simulation stopped after a failed check");
  endtask

  task automatic report_mismatch(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    stop_run();
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
    stop_run();
  endtask

  task automatic step_cycles(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  function automatic logic [7:0] flash_byte(input logic [23:0] a);
    return a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'h5A;
  endfunction

  function automatic logic [31:0] flash_word(input logic [23:0] a);
    return {flash_byte(a), flash_byte(a + 24'd1), flash_byte(a + 24'd2),
            flash_byte(a + 24'd3)};
  endfunction

  // Starts 1 ns after a rising edge and returns at the same point
  task automatic apb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    int n;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    step_cycles(1);
    apb_req.penable = 1'b1;
    n = 0;
    // Response sampled mid-cycle
    @(negedge clk_i);
    while (!apb_rsp.pready) begin
      n++;
      if (n > TIMEOUT) report_timeout("pready");
      @(negedge clk_i);
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    step_cycles(1);
    apb_req = '0;
  endtask

  task automatic write_expect(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b1, addr, wdata, rdata, err);
    assert (err == exp_err) else report_mismatch($sformatf(
      "write %h: pslverr %0b, expected %0b", addr, err, exp_err));
  endtask

  task automatic read_expect(input logic [31:0] addr, input logic [31:0] exp_data,
                             input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b0, addr, 32'd0, rdata, err);
    assert (err == exp_err && rdata == exp_data) else report_mismatch($sformatf(
      "read %h: data %h err %0b, expected %h err %0b", addr, rdata, err, exp_data, exp_err));
  endtask

  task automatic flash_read(input logic [23:0] a, input logic [31:0] exp_data,
                            input logic collide);
    logic [31:0] st;
    logic        err;
    int          n;
    write_expect(CMD_ADDR, {8'h03, a}, 1'b0);
    // A second command during the transfer is refused
    if (collide) begin
      write_expect(CMD_ADDR, {8'h03, ~a}, 1'b1);
    end
    n  = 0;
    st = '0;
    while (!st[1]) begin
      apb_xfer(1'b0, FSTAT_ADDR, 32'd0, st, err);
      assert (err == 1'b0) else report_mismatch("flash STATUS read returned pslverr");
      n++;
      if (n > TIMEOUT) report_timeout("flash done");
    end
    assert (st[0] == 1'b0) else report_mismatch("flash busy still set with done");
    read_expect(DATA_ADDR, exp_data, 1'b0);
  endtask

  task automatic check_frame(input logic [7:0] b, output longint t_start);
    int n;
    n = 0;
    while (uart_tx_o) begin
      step_cycles(1);
      n++;
      if (n > TIMEOUT) report_timeout("UART start bit");
    end
    t_start = $time;
    step_cycles(CLKS_PER_BIT / 2);
    assert (uart_tx_o == 1'b0) else report_mismatch("UART start bit not low");
    for (int i = 0; i < 8; i++) begin
      step_cycles(CLKS_PER_BIT);
      assert (uart_tx_o == b[i]) else report_mismatch($sformatf(
        "UART byte %h bit %0d is %0b", b, i, uart_tx_o));
    end
    step_cycles(CLKS_PER_BIT);
    assert (uart_tx_o == 1'b1) else report_mismatch("UART stop bit not high");
  endtask

  task automatic uart_send(input logic [7:0] b);
    longint t_first;
    longint t_second;
    longint t_done;
    write_expect(TXDATA_ADDR, {24'd0, b}, 1'b0);
    // Second write waits in wait states while the first frame runs
    fork
      check_frame(b, t_first);
      begin
        write_expect(TXDATA_ADDR, {24'd0, ~b}, 1'b0);
        t_done = $time;
      end
    join
    assert (t_done - t_first >= FRAME_NS) else report_mismatch($sformatf(
      "second UART write done %0d ns after frame start", t_done - t_first));
    check_frame(~b, t_second);
    // Start bit is already on the line right after the completing edge
    assert (t_second == t_done) else report_mismatch($sformatf(
      "second UART frame started %0d ns after its write", t_second - t_done));
  endtask

  function automatic void add_entry(input logic [2:0] op, input logic [31:0] addr,
                                    input logic [31:0] wdata, input logic [31:0] rdata,
                                    input logic err);
    table_q.push_back({op, addr, wdata, rdata, err});
  endfunction

  function automatic void build_table();
    logic [23:0] a;
    add_entry(OP_FETCH, 32'd0, 32'd0, 32'd0, 1'b0);
    add_entry(OP_RD, STATUS_ADDR, 32'd0, 32'd0, 1'b0);
    add_entry(OP_FETCH, 32'd0, 32'd1, 32'd0, 1'b0);
    add_entry(OP_RD, STATUS_ADDR, 32'd0, 32'd1, 1'b0);
    add_entry(OP_EXIT, EXIT_ADDR, 32'hA5A5_0F00, 32'd0, 1'b0);
    add_entry(OP_RD, EXIT_ADDR, 32'd0, 32'hA5A5_0F00, 1'b0);
    add_entry(OP_EXIT, EXIT_ADDR, 32'h1234_5679, 32'd0, 1'b0);
    add_entry(OP_RD, EXIT_ADDR, 32'd0, 32'h1234_5679, 1'b0);
    for (int i = 0; i < 4; i++) begin
      a = 24'($urandom);
      add_entry(OP_FLASH, {8'd0, a}, 32'd0, flash_word(a), 1'b0);
    end
    a = 24'($urandom);
    add_entry(OP_FBUSY, {8'd0, a}, 32'd0, flash_word(a), 1'b0);
    add_entry(OP_WR, CMD_ADDR, {8'h0B, 24'h000100}, 32'd0, 1'b1);
    add_entry(OP_UART, TXDATA_ADDR, {24'd0, 8'($urandom)}, 32'd0, 1'b0);
    // Holes in the map
    add_entry(OP_RD, 32'h0000_3000, 32'd0, 32'd0, 1'b1);
    add_entry(OP_WR, 32'h0000_3004, 32'hFFFF_FFFF, 32'd0, 1'b1);
    add_entry(OP_RD, 32'h0001_2004, 32'd0, 32'd0, 1'b1);
  endfunction

  initial begin
    entry_t e;
    clk_i          = 1'b0;
    reset_i        = 1'b1;
    apb_req        = '0;
    fetch_enable_i = 1'b0;
    void'($urandom(32'h682421f4));
    build_table();
    repeat (10) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    step_cycles(1);
    assert (flash_cs == 1'b1 && flash_clk == 1'b0) else report_mismatch("flash pins after reset");
    assert (uart_tx_o == 1'b1) else report_mismatch("UART line not idle after reset");
    assert (exit_valid_o == 1'b0) else report_mismatch("exit valid set after reset");
    foreach (table_q[k]) begin
      e = table_q[k];
      case (e.op)
        OP_WR:    write_expect(e.addr, e.wdata, e.err);
        OP_RD:    read_expect(e.addr, e.rdata, e.err);
        OP_FETCH: fetch_enable_i = e.wdata[0];
        OP_EXIT: begin
          write_expect(e.addr, e.wdata, e.err);
          assert (exit_valid_o == 1'b1 && exit_value_o == e.wdata[0]) else report_mismatch(
            $sformatf("exit pins %0b/%0b after writing %h", exit_valid_o, exit_value_o, e.wdata));
        end
        OP_FLASH: flash_read(e.addr[23:0], e.rdata, 1'b0);
        OP_FBUSY: flash_read(e.addr[23:0], e.rdata, 1'b1);
        OP_UART:  uart_send(e.wdata[7:0]);
        default:  report_mismatch("unknown table operation");
      endcase
    end
    $display("No errors");
    $finish;
  end

endmodule

// File: build.f
design/mcu_cfg_pkg.sv
design/mcu_bus_pkg.sv
design/apb_periph_demux.sv
design/soc_ctrl.sv
design/uart_tx.sv
design/spi_flash_ctrl.sv
design/flash_pad_ring.sv
design/mini_mcu_wrapper.sv
test/spi_flash_model.sv
test/tb_mini_mcu.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_mini_mcu
FILELIST  ?= build.f

OBJ_DIR := obj_dir
SIM_BIN := $(OBJ_DIR)/V$(TOP)
LOG     := sim.log
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "No errors" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
